// File: Bender.yml
package:
  name: eth_packet_buffer

sources:
  # RTL, packages first
  - include_dirs:
      - hdl
    files:
      - hdl/eth_stream_pkg.sv
      - hdl/eth_phy_pkg.sv
      - hdl/packet_fifo.sv
      - hdl/nibble_rx.sv
      - hdl/nibble_tx.sv
      - hdl/eth_packet_buffer.sv

  # Testbench, top module tb_eth_packet_buffer
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_eth_packet_buffer.sv

// File: hdl/eth_buffer_defs.svh
`ifndef ETH_BUFFER_DEFS_SVH
`define ETH_BUFFER_DEFS_SVH

////////////////////
// FIFO sizing
////////////////////

// Bytes held by each packet FIFO, must stay a power of two
`define ETH_FIFO_DEPTH 64

// Address bits for one FIFO, log2 of the depth
`define ETH_FIFO_AW 6

////////////////////
// PHY timing
////////////////////

// Enable-low cycles after each frame, twelve byte times at two cycles a byte
`define ETH_IPG_CYCLES 24

`endif

// File: hdl/eth_packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Packet buffer top, host byte streams on one side and the nibble PHY on the other
module eth_packet_buffer import eth_stream_pkg::*, eth_phy_pkg::*; (
    input  wire          clk_125,
    input  wire          i_reset_n,

    // Transmit host side, plain strobe without ready
    input  wire stream_beat_t i_tx_beat,
    input  wire          i_tx_valid,
    input  wire          i_tx_abort,
    output wire          o_tx_drop,

    // PHY
    output wire [3:0]    o_txd,
    output wire          o_tx_en,
    input  wire phy_nibble_t i_rx_nibble,

    // Receive host side, valid/ready
    output wire stream_beat_t o_rx_beat,
    output wire          o_rx_valid,
    input  wire          i_rx_ready,
    output wire          o_rx_drop
);

    ////////////////////
    // Receive path
    ////////////////////

    stream_beat_t rx_wr_beat;
    logic         rx_wr_valid;
    logic         rx_wr_abort;
    logic         rx_pop;

    assign rx_pop = o_rx_valid & i_rx_ready;   // Handshake completes a beat

    nibble_rx rx_deser_i (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .i_nibble  (i_rx_nibble),
        .o_beat    (rx_wr_beat),
        .o_valid   (rx_wr_valid),
        .o_abort   (rx_wr_abort)
    );

    packet_fifo rx_fifo_i (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .i_wr_beat  (rx_wr_beat),
        .i_wr_valid (rx_wr_valid),
        .i_wr_abort (rx_wr_abort),
        .o_drop     (o_rx_drop),
        .o_rd_beat  (o_rx_beat),
        .o_rd_valid (o_rx_valid),
        .i_rd_pop   (rx_pop)
    );

    ////////////////////
    // Transmit path
    ////////////////////

    stream_beat_t tx_rd_beat;
    logic         tx_rd_valid;
    logic         tx_pop;

    packet_fifo tx_fifo_i (
        .clk_125    (clk_125),
        .i_reset_n  (i_reset_n),
        .i_wr_beat  (i_tx_beat),
        .i_wr_valid (i_tx_valid),
        .i_wr_abort (i_tx_abort),
        .o_drop     (o_tx_drop),
        .o_rd_beat  (tx_rd_beat),
        .o_rd_valid (tx_rd_valid),
        .i_rd_pop   (tx_pop)
    );

    nibble_tx tx_ser_i (
        .clk_125   (clk_125),
        .i_reset_n (i_reset_n),
        .i_beat    (tx_rd_beat),
        .i_valid   (tx_rd_valid),
        .o_pop     (tx_pop),
        .o_txd     (o_txd),
        .o_tx_en   (o_tx_en)
    );

endmodule : eth_packet_buffer

`default_nettype wire

// File: hdl/eth_phy_pkg.sv
`default_nettype none

// PHY side types, nibble bus and the serializer/deserializer FSM encodings
package eth_phy_pkg;

    ////////////////////
    // Nibble bus
    ////////////////////

    typedef struct packed {
        logic [3:0] data;   // Nibble, low half of a byte comes first
        logic       dv;     // Data valid, high for the whole frame
        logic       er;     // Receive error from the PHY
    } phy_nibble_t;

    ////////////////////
    // FSM states
    ////////////////////

    // Serializer, LOW and HIGH are the nibble currently on o_txd
    typedef enum logic [1:0] {
        TX_IDLE, TX_LOW, TX_HIGH, TX_GAP
    } tx_state_t;

    // Deserializer, LOW and HIGH are the nibble expected next
    typedef enum logic [1:0] {
        RX_IDLE, RX_LOW, RX_HIGH, RX_FLUSH
    } rx_state_t;

endpackage : eth_phy_pkg

`default_nettype wire

// File: hdl/eth_stream_pkg.sv
`default_nettype none

// Host side byte stream types, shared by both FIFOs and the PHY adapters
package eth_stream_pkg;

    ////////////////////
    // Byte beat
    ////////////////////

    // One byte of a packet plus its end marker
    typedef struct packed {
        logic [7:0] data;   // Payload byte
        logic       last;   // Final byte of the packet
    } stream_beat_t;

endpackage : eth_stream_pkg

`default_nettype wire

// File: hdl/nibble_rx.sv
`timescale 1ns/1ps
`default_nettype none

// Deserializer, PHY nibbles in, byte beats out with last and abort marking
module nibble_rx import eth_stream_pkg::*, eth_phy_pkg::*; (
    input  wire          clk_125,
    input  wire          i_reset_n,
    input  wire phy_nibble_t i_nibble,  // Sampled every cycle
    output stream_beat_t o_beat,
    output logic         o_valid,
    output logic         o_abort        // Set with the final beat of a bad frame
);

    rx_state_t  state;
    logic [3:0] low_nib;     // Low half waiting for its high nibble
    logic [7:0] pend_byte;   // Completed byte held back by one beat
    logic       pend_vld;    // pend_byte holds a byte of this frame

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state    <= RX_IDLE;
            pend_vld <= 1'b0;
            o_valid  <= 1'b0;
            o_abort  <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            o_abort <= 1'b0;
            case (state)
                RX_IDLE: if (i_nibble.dv) begin           // First low nibble
                    pend_vld <= 1'b0;
                    state    <= i_nibble.er ? RX_FLUSH : RX_HIGH;
                end
                RX_HIGH: if (!i_nibble.dv) begin          // Ended on an odd nibble
                    o_valid <= 1'b1;
                    o_abort <= 1'b1;
                    state   <= RX_IDLE;
                end else if (i_nibble.er) begin
                    state <= RX_FLUSH;
                end else begin
                    o_valid  <= pend_vld;                 // Previous byte goes out
                    pend_vld <= 1'b1;
                    state    <= RX_LOW;
                end
                RX_LOW: if (!i_nibble.dv) begin           // Clean end, flush with last
                    o_valid <= 1'b1;
                    state   <= RX_IDLE;
                end else begin
                    state <= i_nibble.er ? RX_FLUSH : RX_HIGH;
                end
                RX_FLUSH: if (!i_nibble.dv) begin         // Bad frame, tell FIFO to rewind
                    o_valid <= 1'b1;
                    o_abort <= 1'b1;
                    state   <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    ////////////////////
    // Byte assembly
    ////////////////////

    always_ff @(posedge clk_125) begin
        if (i_nibble.dv && (state == RX_IDLE || state == RX_LOW)) begin
            low_nib <= i_nibble.data;
        end
        if (i_nibble.dv && state == RX_HIGH) begin
            pend_byte <= {i_nibble.data, low_nib};
        end
        o_beat.data <= pend_byte;        // Old value, the new byte stays pending
        o_beat.last <= !i_nibble.dv;     // Only emitted on dv low at frame end
    end

endmodule : nibble_rx

`default_nettype wire

// File: hdl/nibble_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_buffer_defs.svh"

// Serializer that sends committed packets as nibbles and then holds an inter-frame gap
module nibble_tx import eth_stream_pkg::*, eth_phy_pkg::*; (
    input  wire          clk_125,
    input  wire          i_reset_n,
    input  wire stream_beat_t i_beat,   // Show-ahead FIFO head
    input  wire          i_valid,       // Complete packet available
    output logic         o_pop,         // Takes i_beat on this edge
    output logic [3:0]   o_txd,
    output logic         o_tx_en
);

    localparam int unsigned IPG = `ETH_IPG_CYCLES;
    localparam int          GW  = $clog2(IPG);

    tx_state_t    state;      // Nibble currently driven on o_txd
    stream_beat_t cur_beat;   // Byte being sent
    logic [GW-1:0] gap_cnt;
    logic         gap_done;   // Final gap cycle

    assign gap_done = (gap_cnt == GW'(IPG - 1));

    ////////////////////
    // Pop decision
    ////////////////////

    always_comb begin
        case (state)
            TX_IDLE: o_pop = i_valid;
            TX_HIGH: o_pop = i_valid && !cur_beat.last;   // Next byte follows without a gap
            TX_GAP:  o_pop = i_valid && gap_done;         // Start right as gap ends
            default: o_pop = 1'b0;
        endcase
    end

    always_ff @(posedge clk_125) begin
        if (o_pop) begin
            cur_beat <= i_beat;
        end
    end

    ////////////////////
    // Nibble FSM
    ////////////////////

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            state   <= TX_IDLE;
            o_txd   <= '0;
            o_tx_en <= 1'b0;
            gap_cnt <= '0;
        end else if (o_pop) begin
            state   <= TX_LOW;
            o_txd   <= i_beat.data[3:0];    // Low nibble first
            o_tx_en <= 1'b1;
        end else begin
            case (state)
                TX_LOW: begin
                    state <= TX_HIGH;
                    o_txd <= cur_beat.data[7:4];
                end
                TX_HIGH: begin
                    o_tx_en <= 1'b0;
                    o_txd   <= '0;
                    gap_cnt <= '0;
                    state   <= TX_GAP;      // Only a last byte gets here without a pop
                end
                TX_GAP: begin
                    if (gap_done) state <= TX_IDLE;
                    else gap_cnt <= gap_cnt + 1'b1;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule : nibble_tx

`default_nettype wire

// File: hdl/packet_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_buffer_defs.svh"

// Show-ahead byte FIFO that only exposes complete packets to the read side
module packet_fifo import eth_stream_pkg::*; (
    input  wire          clk_125,
    input  wire          i_reset_n,     // Synchronous, active low

    input  wire stream_beat_t i_wr_beat,
    input  wire          i_wr_valid,    // Write strobe, no back-pressure
    input  wire          i_wr_abort,    // Throw away the packet in progress
    output logic         o_drop,        // One pulse per discarded packet

    output stream_beat_t o_rd_beat,     // Head of the FIFO, valid while o_rd_valid
    output logic         o_rd_valid,    // At least one committed packet stored
    input  wire          i_rd_pop
);

    localparam int AW = `ETH_FIFO_AW;

    ////////////////////
    // Storage and pointers
    ////////////////////

    stream_beat_t mem [`ETH_FIFO_DEPTH];   // Packet bytes, no reset needed

    logic [AW:0] wr_ptr;    // Speculative write pointer, moves every stored byte
    logic [AW:0] cmt_ptr;   // End of the last committed packet
    logic [AW:0] rd_ptr;
    logic [AW:0] pkt_cnt;   // Committed packets not yet fully read
    logic        discard;   // Swallowing the rest of an overflowed packet

    logic [AW:0] used;      // Includes uncommitted bytes
    logic        full;
    logic        wr_ok;     // Byte really goes into memory
    logic        commit;
    logic        rd_fire;
    logic        rd_last;   // Last byte of a packet leaves

    assign used    = wr_ptr - rd_ptr;
    assign full    = used[AW];                 // Extra pointer bit set only at depth
    assign wr_ok   = i_wr_valid && !i_wr_abort && !discard && !full;
    assign commit  = wr_ok && i_wr_beat.last;
    assign rd_fire = i_rd_pop && o_rd_valid;
    assign rd_last = rd_fire && o_rd_beat.last;

    // Read side only sees data once a packet is committed
    assign o_rd_valid = (pkt_cnt != '0);
    assign o_rd_beat  = mem[rd_ptr[AW-1:0]];   // Asynchronous read gives show-ahead

    always_ff @(posedge clk_125) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_beat;
        end
    end

    ////////////////////
    // Write side control
    ////////////////////

    always_ff @(posedge clk_125) begin
        if (!i_reset_n) begin
            wr_ptr  <= '0;
            cmt_ptr <= '0;
            rd_ptr  <= '0;
            pkt_cnt <= '0;
            discard <= 1'b0;
            o_drop  <= 1'b0;
        end else begin
            o_drop <= 1'b0;

            if (i_wr_valid) begin
                if (discard) begin
                    // Overflowed packet ends here
                    if (i_wr_beat.last || i_wr_abort) begin
                        discard <= 1'b0;
                        o_drop  <= 1'b1;
                    end
                end else if (i_wr_abort || full) begin
                    wr_ptr <= cmt_ptr;              // Rewind over the partial packet
                    if (i_wr_abort || i_wr_beat.last) begin
                        o_drop <= 1'b1;             // Packet ends on this beat
                    end else begin
                        discard <= 1'b1;            // Ignore bytes up to the last one
                    end
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (i_wr_beat.last) begin
                        cmt_ptr <= wr_ptr + 1'b1;   // Packet now visible to the reader
                    end
                end
            end

            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // Commit and last-read together cancel out
            if (commit && !rd_last) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end else if (rd_last && !commit) begin
                pkt_cnt <= pkt_cnt - 1'b1;
            end
        end
    end

endmodule : packet_fifo

`default_nettype wire

// File: testbench/tb_eth_packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_buffer_defs.svh"

// Packet buffer testbench with reference models for both directions
module tb_eth_packet_buffer import eth_stream_pkg::*, eth_phy_pkg::*;;

    typedef logic [7:0] byte_q_t [$];
    typedef logic [3:0] nib_q_t [$];

    localparam int TIMEOUT = 3000;   // Cycles allowed for any single wait

    logic         clk_125;
    logic         i_reset_n;
    stream_beat_t i_tx_beat;
    logic         i_tx_valid;
    logic         i_tx_abort;
    logic         o_tx_drop;
    logic [3:0]   o_txd;
    logic         o_tx_en;
    phy_nibble_t  i_rx_nibble;
    stream_beat_t o_rx_beat;
    logic         o_rx_valid;
    logic         i_rx_ready;
    logic         o_rx_drop;

    integer seed       = 42914;   // Lengths and data
    integer ready_seed = 42914;   // Receive stalls on their own stream
    logic   rand_ready = 1'b0;

    nib_q_t       tx_exp_nib;         // Nibbles still to appear on o_txd
    int           tx_exp_len [$];     // Nibble count of each pending packet
    stream_beat_t rx_exp_beat [$];
    int rx_lasts_pushed = 0;
    int rx_lasts_seen   = 0;
    int tx_drops = 0;
    int rx_drops = 0;
    int tx_run = 0;                   // Nibbles in the current enable burst
    int tx_gap = 0;                   // Enable-low cycles so far
    int tx_last_gap = 0;              // Gap before the latest burst
    logic tx_en_q = 1'b0;
    logic rx_in_pkt = 1'b0;
    int errors = 0;
    int tests_run = 0;
    int tests_passed = 0;

    eth_packet_buffer dut_i (
        .clk_125     (clk_125),
        .i_reset_n   (i_reset_n),
        .i_tx_beat   (i_tx_beat),
        .i_tx_valid  (i_tx_valid),
        .i_tx_abort  (i_tx_abort),
        .o_tx_drop   (o_tx_drop),
        .o_txd       (o_txd),
        .o_tx_en     (o_tx_en),
        .i_rx_nibble (i_rx_nibble),
        .o_rx_beat   (o_rx_beat),
        .o_rx_valid  (o_rx_valid),
        .i_rx_ready  (i_rx_ready),
        .o_rx_drop   (o_rx_drop)
    );

    initial begin
        clk_125 = 1'b0;
        forever #4 clk_125 = ~clk_125;   // 125 MHz
    end

    // Host ready with random stalls while rand_ready is set
    initial begin
        i_rx_ready = 1'b1;
        forever begin
            @(negedge clk_125);
            i_rx_ready = rand_ready ? (($random(ready_seed) & 1) == 1) : 1'b1;
        end
    end

    ////////////////////
    // Reference models
    ////////////////////

    // Bytes the FIFO should deliver or an empty queue for a dropped packet
    function automatic byte_q_t expected_bytes(input byte_q_t frame, input bit bad);
        byte_q_t none;
        if (bad || frame.size() > `ETH_FIFO_DEPTH) return none;
        return frame;
    endfunction

    function automatic nib_q_t nibbles_of(input byte_q_t bytes);
        nib_q_t nibs;
        foreach (bytes[i]) begin
            nibs.push_back(bytes[i][3:0]);   // Low nibble goes first
            nibs.push_back(bytes[i][7:4]);
        end
        return nibs;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic byte_q_t random_packet(input int len);
        byte_q_t pkt;
        repeat (len) pkt.push_back($random(seed));
        return pkt;
    endfunction

    function automatic void expect_tx(input byte_q_t pkt, input bit bad);
        nib_q_t nibs;
        nibs = nibbles_of(expected_bytes(pkt, bad));
        if (nibs.size() == 0) return;          // Dropped packet never reaches the wire
        foreach (nibs[i]) tx_exp_nib.push_back(nibs[i]);
        tx_exp_len.push_back(nibs.size());
    endfunction

    function automatic void expect_rx(input byte_q_t frame, input bit bad);
        byte_q_t kept;
        stream_beat_t beat;
        kept = expected_bytes(frame, bad);
        foreach (kept[i]) begin
            beat.data = kept[i];
            beat.last = (i == kept.size() - 1);
            rx_exp_beat.push_back(beat);
        end
        if (kept.size() != 0) rx_lasts_pushed++;
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    // abort_at < 0 sends the whole packet
    task automatic send_tx_packet(input byte_q_t pkt, input int abort_at);
        int i;
        for (i = 0; i < pkt.size(); i++) begin
            @(negedge clk_125);
            i_tx_valid     = 1'b1;
            i_tx_beat.data = pkt[i];
            i_tx_beat.last = (i == pkt.size() - 1);
            i_tx_abort     = (i == abort_at);   // Abort beat is not stored
            if (i == abort_at) break;
        end
        @(negedge clk_125);
        i_tx_valid = 1'b0;
        i_tx_abort = 1'b0;
        i_tx_beat  = '0;
    endtask

    // Negative err_nib sends no error nibble and cut drops the final high nibble
    task automatic send_phy_frame(input byte_q_t frame, input int err_nib, input bit cut);
        int k;
        int n;
        n = 2 * frame.size() - (cut ? 1 : 0);
        for (k = 0; k < n; k++) begin
            @(negedge clk_125);
            i_rx_nibble.data = k[0] ? frame[k / 2][7:4] : frame[k / 2][3:0];
            i_rx_nibble.dv   = 1'b1;
            i_rx_nibble.er   = (k == err_nib);
        end
        @(negedge clk_125);
        i_rx_nibble = '0;                       // Frame ends on dv low
        @(negedge clk_125);
    endtask

    task automatic wait_tx_pending(input int max_pkts);
        int n;
        n = 0;
        while (tx_exp_len.size() > max_pkts && n < TIMEOUT) begin
            @(negedge clk_125);
            n++;
        end
        if (tx_exp_len.size() > max_pkts) begin
            $display("Timeout: %0d transmit packets never came out", tx_exp_len.size());
            errors++;
        end
    endtask

    task automatic wait_rx_pending(input int max_pkts);
        int n;
        n = 0;
        while (rx_lasts_pushed - rx_lasts_seen > max_pkts && n < TIMEOUT) begin
            @(negedge clk_125);
            n++;
        end
        if (rx_lasts_pushed - rx_lasts_seen > max_pkts) begin
            $display("Timeout: receive packets were never read back");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name,
                     errors - errors_before);
        end
    endtask

    ////////////////////
    // Output checker
    ////////////////////

    always @(posedge clk_125) begin : compare_outputs
        logic [3:0]   exp_nib;
        int           exp_len;
        stream_beat_t exp_beat;
        if (i_reset_n) begin
            if (o_tx_en) begin
                if (!tx_en_q) tx_last_gap = tx_gap;   // Start of a burst ends the gap
                tx_run++;
                if (tx_exp_nib.size() == 0) begin
                    $display("Nibble on o_txd while no packet was expected");
                    errors++;
                end else begin
                    exp_nib = tx_exp_nib.pop_front();
                    assert (o_txd == exp_nib) else begin
                        $display("ERROR: o_txd got %h expected %h", o_txd, exp_nib);
                        errors++;
                    end
                end
            end else begin
                if (tx_en_q) begin                    // Burst ended
                    exp_len = (tx_exp_len.size() != 0) ? tx_exp_len.pop_front() : 0;
                    assert (tx_run == exp_len) else begin
                        $display("ERROR: o_tx_en burst got %h nibbles expected %h",
                                 tx_run, exp_len);
                        errors++;
                    end
                    tx_run = 0;
                    tx_gap = 0;
                end
                tx_gap++;
            end
            tx_en_q = o_tx_en;
            if (o_tx_drop) tx_drops++;
            if (o_rx_drop) rx_drops++;

            // Valid must hold once a packet has started
            assert (o_rx_valid || !rx_in_pkt) else begin
                $display("ERROR: o_rx_valid got %h expected %h", o_rx_valid, 1'b1);
                errors++;
            end
            if (o_rx_valid && i_rx_ready) begin
                if (rx_exp_beat.size() == 0) begin
                    $display("Beat on o_rx_beat while no packet was expected");
                    errors++;
                end else begin
                    exp_beat = rx_exp_beat.pop_front();
                    assert (o_rx_beat == exp_beat) else begin
                        $display("ERROR: o_rx_beat got %h expected %h", o_rx_beat, exp_beat);
                        errors++;
                    end
                    if (exp_beat.last) rx_lasts_seen++;
                end
                rx_in_pkt = !o_rx_beat.last;
            end
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        byte_q_t pkt;
        int e0;
        int d0;
        i_reset_n   = 1'b0;
        i_tx_beat   = '0;
        i_tx_valid  = 1'b0;
        i_tx_abort  = 1'b0;
        i_rx_nibble = '0;
        repeat (3) @(posedge clk_125);              // Three clock edges in reset
        @(negedge clk_125);
        i_reset_n = 1'b1;

        e0 = errors;                                // Random packets in order
        repeat (8) begin
            wait_tx_pending(1);                     // Keeps the FIFO below depth
            pkt = random_packet(rand_range(1, 24));
            expect_tx(pkt, 1'b0);
            send_tx_packet(pkt, -1);
        end
        wait_tx_pending(0);
        report_test("transmit data", e0);

        e0 = errors;                                // Second packet ready before gap ends
        pkt = random_packet(8);
        expect_tx(pkt, 1'b0);
        send_tx_packet(pkt, -1);
        pkt = random_packet(6);
        expect_tx(pkt, 1'b0);
        send_tx_packet(pkt, -1);
        wait_tx_pending(0);
        assert (tx_last_gap == `ETH_IPG_CYCLES) else begin
            $display("ERROR: o_tx_en low cycles got %h expected %h", tx_last_gap,
                     `ETH_IPG_CYCLES);
            errors++;
        end
        report_test("inter-frame gap", e0);

        e0 = errors;
        d0 = tx_drops;
        pkt = random_packet(10);
        expect_tx(pkt, 1'b0);
        send_tx_packet(pkt, -1);
        pkt = random_packet(12);                    // Aborted halfway
        expect_tx(pkt, 1'b1);
        send_tx_packet(pkt, 5);
        pkt = random_packet(`ETH_FIFO_DEPTH + 6);   // Overflows the FIFO
        expect_tx(pkt, 1'b0);
        send_tx_packet(pkt, -1);
        pkt = random_packet(9);
        expect_tx(pkt, 1'b0);
        send_tx_packet(pkt, -1);
        wait_tx_pending(0);
        assert (tx_drops - d0 == 2) else begin
            $display("ERROR: o_tx_drop pulses got %h expected %h", tx_drops - d0, 2);
            errors++;
        end
        report_test("transmit abort and overflow", e0);

        e0 = errors;
        rand_ready = 1'b1;
        repeat (8) begin
            wait_rx_pending(1);
            pkt = random_packet(rand_range(1, 24));
            expect_rx(pkt, 1'b0);
            send_phy_frame(pkt, -1, 1'b0);
        end
        wait_rx_pending(0);
        rand_ready = 1'b0;
        report_test("receive data with stalls", e0);

        e0 = errors;
        d0 = rx_drops;
        pkt = random_packet(12);
        expect_rx(pkt, 1'b1);
        send_phy_frame(pkt, 3, 1'b0);               // Error on the second high nibble
        pkt = random_packet(10);
        expect_rx(pkt, 1'b1);
        send_phy_frame(pkt, -1, 1'b1);              // Odd nibble count
        pkt = random_packet(`ETH_FIFO_DEPTH + 6);
        expect_rx(pkt, 1'b0);
        send_phy_frame(pkt, -1, 1'b0);
        pkt = random_packet(16);
        expect_rx(pkt, 1'b0);
        send_phy_frame(pkt, -1, 1'b0);
        wait_rx_pending(0);
        repeat (20) @(negedge clk_125);             // Room for stray beats to show up
        assert (rx_drops - d0 == 3) else begin
            $display("ERROR: o_rx_drop pulses got %h expected %h", rx_drops - d0, 3);
            errors++;
        end
        report_test("receive discard", e0);

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_eth_packet_buffer

`default_nettype wire

// File: verilog.f
+incdir+hdl
hdl/eth_stream_pkg.sv
hdl/eth_phy_pkg.sv
hdl/packet_fifo.sv
hdl/nibble_rx.sv
hdl/nibble_tx.sv
hdl/eth_packet_buffer.sv
testbench/tb_eth_packet_buffer.sv
